// File: Makefile
TOP := cr16DatapathTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f vlog.f

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall \
		--top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

// File: design/cr16Alu.sv
// CR-16 ALU with flag generation
`timescale 1ns/1ps

module cr16Alu import cr16Pkg::*; (
	input logic [dataWidth-1:0] regSrc,
	input logic [dataWidth-1:0] regDst,
	input aluOpT aluOp,
	output logic [dataWidth-1:0] aluResult,
	output flagsT flags
);

	localparam int msb = dataWidth - 1;

	// Extra bit holds carry out or borrow
	logic [dataWidth:0] sum;
	logic [dataWidth:0] diff;
	logic addOverflow;
	logic subOverflow;
	logic signedLess;

	assign sum = {1'b0, regDst} + {1'b0, regSrc};
	assign diff = {1'b0, regDst} - {1'b0, regSrc};

	// Same operand signs but result sign flipped
	assign addOverflow = (regDst[msb] == regSrc[msb]) && (sum[msb] != regDst[msb]);

	// Operand signs differ and result sign differs from regDst
	assign subOverflow = (regDst[msb] != regSrc[msb]) && (diff[msb] != regDst[msb]);

	assign signedLess = $signed(regDst) < $signed(regSrc);

	always_comb begin
		aluResult = regDst;
		flags = '0;

		case (aluOp)
			aluAdd: begin
				aluResult = sum[msb:0];
				flags.carry = sum[dataWidth];
				flags.flag = addOverflow;
				flags.zero = (sum[msb:0] == '0);
				flags.negative = sum[msb];
			end
			aluSub: begin
				aluResult = diff[msb:0];
				// Borrow out of the subtract
				flags.carry = diff[dataWidth];
				flags.flag = subOverflow;
				flags.zero = (diff[msb:0] == '0);
				flags.negative = diff[msb];
			end
			aluAnd: aluResult = regDst & regSrc;
			aluOr: aluResult = regDst | regSrc;
			aluXor: aluResult = regDst ^ regSrc;
			aluCmp: begin
				// Result stays regDst
				aluResult = regDst;
				flags.low = (regDst < regSrc);
				flags.negative = signedLess;
				flags.zero = (regDst == regSrc);
			end
			aluPass: aluResult = regSrc;
			default: aluResult = regDst;
		endcase
	end

endmodule

// File: design/cr16Datapath.sv
// CR-16 execute datapath top level
`timescale 1ns/1ps

module cr16Datapath import cr16Pkg::*; (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input instrT instr,
	input logic [dataWidth-1:0] pc,
	output logic [dataWidth-1:0] resultData,
	output flagsT psr
);

	ctrlT ctrl;
	flagsT aluFlags;
	logic [dataWidth-1:0] immd;
	logic [dataWidth-1:0] srcValue;
	logic [dataWidth-1:0] dstValue;
	logic [dataWidth-1:0] aluDst;
	logic [dataWidth-1:0] aluSrc;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] shiftResult;

	cr16Decoder decoder (
		.instr(instr),
		.instrValid(instrValid),
		.ctrl(ctrl),
		.immd(immd)
	);

	cr16RegFile regFile (
		.clk(clk),
		.reset(reset),
		.regWrite(ctrl.regWrite),
		.flagWrite(ctrl.flagWrite),
		.srcAddr(ctrl.srcAddr),
		.dstAddr(ctrl.dstAddr),
		.wrData(resultData),
		.flagsIn(aluFlags),
		.srcValue(srcValue),
		.dstValue(dstValue),
		.psr(psr)
	);

	// PC operand for LPC
	assign aluDst = ctrl.pcInstruction ? pc : dstValue;

	// Register or immediate B operand
	assign aluSrc = ctrl.rTypeInstruction ? srcValue : immd;

	cr16Alu alu (
		.regSrc(aluSrc),
		.regDst(aluDst),
		.aluOp(ctrl.aluOp),
		.aluResult(aluResult),
		.flags(aluFlags)
	);

	// Shifts act on the destination operand
	cr16Shifter shifter (
		.shiftInput(aluDst),
		.shiftAmount(ctrl.shiftAmount),
		.shiftResult(shiftResult)
	);

	// Writeback select
	assign resultData = ctrl.shiftInstruction ? shiftResult : aluResult;

endmodule

// File: design/cr16Decoder.sv
// CR-16 instruction decoder
`timescale 1ns/1ps

module cr16Decoder import cr16Pkg::*; (
	input instrT instr,
	input logic instrValid,
	output ctrlT ctrl,
	output logic [dataWidth-1:0] immd
);

	opcodeT opcode;

	// Opcode sits at the same bits in both views
	assign opcode = instr.rForm.opcode;

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPass;
		ctrl.dstAddr = instr.rForm.dst;
		immd = '0;

		// Operand form
		case (opcode)
			ADD, SUB, AND, OR, XOR, CMP, MOV, LSH: begin
				ctrl.rTypeInstruction = 1'b1;
				ctrl.srcAddr = instr.rForm.src;
			end
			default: begin
				// Sign extend the 8-bit immediate
				immd = {{(dataWidth-immWidth){instr.iForm.imm[immWidth-1]}}, instr.iForm.imm};
			end
		endcase

		// Operation and write enables
		case (opcode)
			ADD, ADDI: begin
				ctrl.aluOp = aluAdd;
				ctrl.regWrite = 1'b1;
				ctrl.flagWrite = 1'b1;
			end
			SUB, SUBI: begin
				ctrl.aluOp = aluSub;
				ctrl.regWrite = 1'b1;
				ctrl.flagWrite = 1'b1;
			end
			AND, ANDI: begin
				ctrl.aluOp = aluAnd;
				ctrl.regWrite = 1'b1;
			end
			OR, ORI: begin
				ctrl.aluOp = aluOr;
				ctrl.regWrite = 1'b1;
			end
			XOR, XORI: begin
				ctrl.aluOp = aluXor;
				ctrl.regWrite = 1'b1;
			end
			CMP, CMPI: begin
				// Flags only, destination untouched
				ctrl.aluOp = aluCmp;
				ctrl.flagWrite = 1'b1;
			end
			MOV, MOVI: begin
				ctrl.aluOp = aluPass;
				ctrl.regWrite = 1'b1;
			end
			LSH: begin
				ctrl.shiftInstruction = 1'b1;
				ctrl.shiftAmount = instr.rForm.extra;
				ctrl.regWrite = 1'b1;
			end
			LPC: begin
				// PC plus immediate
				ctrl.pcInstruction = 1'b1;
				ctrl.aluOp = aluAdd;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl.aluOp = aluPass;
		endcase

		// Idle cycle writes nothing
		ctrl.regWrite = ctrl.regWrite && instrValid;
		ctrl.flagWrite = ctrl.flagWrite && instrValid;
	end

endmodule

// File: design/cr16Pkg.sv
// CR-16 execute datapath definitions
package cr16Pkg;

	// Fixed CR-16 word geometry
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;
	localparam int shiftWidth = 4;
	localparam int immWidth = 8;

	// Opcodes 0 to 7 are register form, 8 to 15 immediate form
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		CMP  = 4'h5,
		MOV  = 4'h6,
		LSH  = 4'h7,
		ADDI = 4'h8,
		SUBI = 4'h9,
		ANDI = 4'ha,
		ORI  = 4'hb,
		XORI = 4'hc,
		CMPI = 4'hd,
		MOVI = 4'he,
		LPC  = 4'hf
	} opcodeT;

	// ALU operations
	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluAnd  = 3'd2,
		aluOr   = 3'd3,
		aluXor  = 3'd4,
		aluCmp  = 3'd5,
		aluPass = 3'd6
	} aluOpT;

	// Processor status word, MSB first
	typedef struct packed {
		logic negative;
		logic zero;
		logic flag;
		logic low;
		logic carry;
	} flagsT;

	// Register form of the instruction word
	typedef struct packed {
		opcodeT opcode;
		logic [regAddrWidth-1:0] dst;
		logic [regAddrWidth-1:0] src;
		logic [shiftWidth-1:0] extra;
	} rFormT;

	// Immediate form, same opcode and dst positions
	typedef struct packed {
		opcodeT opcode;
		logic [regAddrWidth-1:0] dst;
		logic [immWidth-1:0] imm;
	} iFormT;

	typedef union packed {
		rFormT rForm;
		iFormT iForm;
	} instrT;

	// Decoded control levels
	typedef struct packed {
		logic rTypeInstruction;
		logic shiftInstruction;
		logic pcInstruction;
		logic regWrite;
		logic flagWrite;
		aluOpT aluOp;
		logic [shiftWidth-1:0] shiftAmount;
		logic [regAddrWidth-1:0] srcAddr;
		logic [regAddrWidth-1:0] dstAddr;
	} ctrlT;

endpackage

// File: design/cr16RegFile.sv
// CR-16 register file and status word
`timescale 1ns/1ps

module cr16RegFile import cr16Pkg::*; (
	input logic clk,
	input logic reset,
	input logic regWrite,
	input logic flagWrite,
	input logic [regAddrWidth-1:0] srcAddr,
	input logic [regAddrWidth-1:0] dstAddr,
	input logic [dataWidth-1:0] wrData,
	input flagsT flagsIn,
	output logic [dataWidth-1:0] srcValue,
	output logic [dataWidth-1:0] dstValue,
	output flagsT psr
);

	// General registers
	logic [dataWidth-1:0] regs [regCount];

	// Combinational read ports
	assign srcValue = regs[srcAddr];
	assign dstValue = regs[dstAddr];

	// Register writes at the rising edge
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[dstAddr] <= wrData;
		end
	end

	// Status word held until the next flag-setting instruction
	always_ff @(posedge clk) begin
		if (!reset) begin
			psr <= '0;
		end else if (flagWrite) begin
			psr <= flagsIn;
		end
	end

endmodule

// File: design/cr16Shifter.sv
// CR-16 logical shifter
`timescale 1ns/1ps

module cr16Shifter import cr16Pkg::*; (
	input logic [dataWidth-1:0] shiftInput,
	input logic [shiftWidth-1:0] shiftAmount,
	output logic [dataWidth-1:0] shiftResult
);

	// Magnitude of a negative amount, 1 to 8
	logic [shiftWidth-1:0] rightAmount;
	logic rightShift;

	// Sign bit picks the direction
	assign rightShift = shiftAmount[shiftWidth-1];
	assign rightAmount = ~shiftAmount + 1'b1;

	always_comb begin
		if (rightShift) begin
			shiftResult = shiftInput >> rightAmount;
		end else begin
			shiftResult = shiftInput << shiftAmount;
		end
	end

endmodule

// File: tb/cr16DatapathTb.sv
// CR-16 datapath testbench
`timescale 1ns/1ps

module cr16DatapathTb import cr16Pkg::*; ();

	localparam int maxSteps = 64;
	localparam int wordsPerStep = 5;
	localparam int resetCycles = 8;
	localparam int timeoutMargin = 20;
	localparam int sampleDelay = 36;
	localparam logic [15:0] endMarker = 16'h000f;

	// One line of the stimulus file
	typedef struct packed {
		logic valid;
		instrT instr;
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] result;
		flagsT psr;
	} stepT;

	logic clk;
	logic reset;
	logic instrValid;
	instrT instr;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] resultData;
	flagsT psr;

	logic [15:0] stimWords [wordsPerStep*maxSteps];
	stepT steps [$];
	int stepIndex;
	int cycleCount = 0;
	int cycleLimit = maxSteps + resetCycles + timeoutMargin;
	int unsigned seedValue;
	logic [31:0] idleBits;

	cr16TbClock clockGen (
		.clk(clk),
		.reset(reset)
	);

	cr16Datapath DUT (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.resultData(resultData),
		.psr(psr)
	);

	task automatic stopRun();
		$display("sim failed");
		$fatal(1, "run stopped at step %0d", stepIndex);
	endtask

	task automatic checkValue(
		input string name,
		input logic [15:0] expected,
		input logic [15:0] actual
	);
		if (actual !== expected) begin
			$display("** Error: %s at step %0d expected %h, got %h",
				name, stepIndex, expected, actual);
			stopRun();
		end
	endtask

	// Five hex words per step and a closing line whose valid field is f
	task automatic loadStimulus();
		stepT rec;
		int base;
		bit found;
		found = 1'b0;
		$readmemh("tb/datapathStimulus.mem", stimWords);
		for (int i = 0; i < maxSteps && !found; i++) begin
			base = i * wordsPerStep;
			if (stimWords[base] == endMarker) begin
				found = 1'b1;
			end else begin
				rec.valid = stimWords[base][0];
				rec.instr = stimWords[base+1];
				rec.pc = stimWords[base+2];
				rec.result = stimWords[base+3];
				rec.psr = stimWords[base+4][4:0];
				steps.push_back(rec);
			end
		end
		if (!found || steps.size() == 0) begin
			$display("Stimulus file is missing, empty or has no end marker");
			stopRun();
		end
	endtask

	// Cycle budget covers reset, every step and a margin
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Simulation timed out after %0d cycles", cycleCount);
			stopRun();
		end
	end

	initial begin
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		stepIndex = 0;
		seedValue = $urandom(32'h1d56);
		loadStimulus();
		cycleLimit = steps.size() + resetCycles + timeoutMargin;

		@(posedge reset);
		foreach (steps[i]) begin
			stepIndex = i;
			@(posedge clk);
			instrValid <= steps[i].valid;
			pc <= steps[i].pc;
			if (steps[i].valid) begin
				instr <= steps[i].instr;
			end else begin
				// Random opcode and operand aimed at r6, read before and after
				idleBits = $urandom;
				instr <= {idleBits[15:12], 4'h6, idleBits[7:0]};
			end

			// Sample just ahead of the next edge
			#sampleDelay;
			if (steps[i].valid) begin
				checkValue("resultData", steps[i].result, resultData);
			end
			checkValue("psr", {11'b0, steps[i].psr}, {11'b0, psr});
		end

		@(posedge clk);
		instrValid <= 1'b0;
		$display("sim passed");
		$finish;
	end

endmodule

// File: tb/cr16Datapath_props.sv
// Datapath assertions
`timescale 1ns/1ps

module cr16DatapathProps import cr16Pkg::*; (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input ctrlT ctrl,
	input flagsT psr
);

	// Status word cleared by the reset just released
	statusClearAfterReset: assert property (
		@(posedge clk) $rose(reset) |-> (psr == '0)
	) else $error("status word not clear one cycle after reset");

	// Idle cycle leaves the status word as it was
	noWriteWhenIdle: assert property (
		@(posedge clk) disable iff (!reset)
		!instrValid |=> $stable(psr)
	) else $error("status word written in an idle cycle");

	// Shifter and PC operand never selected together
	shiftPcExclusive: assert property (
		@(posedge clk) disable iff (!reset)
		!(ctrl.shiftInstruction && ctrl.pcInstruction)
	) else $error("shift and PC-relative selects both set");

endmodule

bind cr16Datapath cr16DatapathProps props (
	.clk(clk),
	.reset(reset),
	.instrValid(instrValid),
	.ctrl(ctrl),
	.psr(psr)
);

// File: tb/cr16TbClock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module cr16TbClock (
	output logic clk,
	output logic reset
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Held low for the first eight rising edges
	initial begin
		reset = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

// File: tb/datapathStimulus.mem
// Columns: valid instr pc result psr, in hex; psr is the status word seen during the step
// result is ignored when valid is 0; a line with valid f ends the list
// Sign-extended loads read back through MOV
1 e185 0000 ff85 00
1 e27f 0000 007f 00
1 6f10 0000 ff85 00
1 6f20 0000 007f 00
1 e3ff 0000 ffff 00
1 6f30 0000 ffff 00
// Add and subtract with carry, overflow, zero and negative
1 0230 0000 007e 00
1 e4ff 0000 ffff 01
1 740f 0000 7fff 01
1 8401 0000 8000 01
1 9401 0000 7fff 14
1 1440 0000 0000 04
1 1410 0000 007b 08
1 0110 0000 ff0a 01
1 8301 0000 0000 11
1 9280 0000 00fe 09
// Logic operations keep the status word
1 2210 0000 000a 01
1 b270 0000 007a 01
1 4210 0000 ff70 01
1 a23c 0000 0030 01
1 3210 0000 ff3a 01
1 c285 0000 00bf 01
1 6f20 0000 00bf 01
// Compares, registers untouched
1 5210 0000 00bf 01
1 5120 0000 ff0a 02
1 d2bf 0000 00bf 10
1 d47b 0000 007b 02
1 6f20 0000 00bf 08
1 6f10 0000 ff0a 08
// Shifts both ways
1 e581 0000 ff81 08
1 7504 0000 f810 08
1 7508 0000 00f8 08
1 7507 0000 7c00 08
1 750d 0000 0f80 08
1 7500 0000 0f80 08
1 6f50 0000 0f80 08
// PC-relative and idle cycles
1 f610 1200 1210 08
1 f7f0 0400 03f0 08
1 6f60 0000 1210 08
0 0000 0000 0000 08
0 0000 0000 0000 08
1 6f60 0000 1210 08
1 6f70 0000 03f0 08
f ffff ffff ffff ff

// File: vlog.f
design/cr16Pkg.sv
design/cr16Decoder.sv
design/cr16RegFile.sv
design/cr16Alu.sv
design/cr16Shifter.sv
design/cr16Datapath.sv
tb/cr16TbClock.sv
tb/cr16Datapath_props.sv
tb/cr16DatapathTb.sv
